// File: verilog/mavg_pkg.sv
// Moving-average shared definitions
// Sample, sum and settings register types and addresses

package mavg_pkg;

  //--------------------------------------------------------------------
  // Stream types
  //--------------------------------------------------------------------

  // I in the upper half, Q in the lower half
  typedef logic        [31:0] iq_sample_t;
  typedef logic signed [15:0] part_t;

  // Window sum, also used as the quotient width
  typedef logic signed [23:0] sum_t;

  //--------------------------------------------------------------------
  // Settings bus types
  //--------------------------------------------------------------------

  // Legal lengths are 1 to 255
  typedef logic [7:0]  win_len_t;
  typedef logic [23:0] divisor_t;

  typedef logic [7:0]  set_addr_t;
  typedef logic [31:0] set_data_t;
  typedef logic [63:0] rb_data_t;

  // Register addresses
  localparam set_addr_t SR_SUM_LEN = 8'd192;
  localparam set_addr_t SR_DIVISOR = 8'd193;

  // Readback for unknown addresses
  localparam rb_data_t RB_BAD_VALUE = 64'h0BAD_C0DE_0BAD_C0DE;

endpackage

// File: verilog/mavg_settings.sv
// Moving-average settings decode
// Holds window length and divisor, pulses clear on length writes, serves readback

`timescale 1ns/10ps

module mavg_settings
  import mavg_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  input  logic      i_set_stb,
  input  set_addr_t i_set_addr,
  input  set_data_t i_set_data,
  input  set_addr_t i_rb_addr,
  output win_len_t  o_win_len,
  output divisor_t  o_divisor,
  output logic      o_clear,
  output rb_data_t  o_rb_data
);

  logic len_wr;
  logic div_wr;

  // Address match for the two registers
  assign len_wr = i_set_stb && (i_set_addr == SR_SUM_LEN);
  assign div_wr = i_set_stb && (i_set_addr == SR_DIVISOR);

  //--------------------------------------------------------------------
  // Registers
  //--------------------------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_win_len <= win_len_t'(1);
      o_divisor <= divisor_t'(1);
      o_clear   <= 1'b0;
    end else begin
      if (len_wr) begin
        o_win_len <= i_set_data[7:0];
      end
      if (div_wr) begin
        o_divisor <= i_set_data[23:0];
      end
      // One cycle, lines up with the new length
      o_clear <= len_wr;
    end
  end

  //--------------------------------------------------------------------
  // Readback
  //--------------------------------------------------------------------

  always_comb begin
    case (i_rb_addr)
      8'd0:    o_rb_data = rb_data_t'(o_win_len);
      8'd1:    o_rb_data = rb_data_t'(o_divisor);
      default: o_rb_data = RB_BAD_VALUE;
    endcase
  end

endmodule

// File: verilog/mavg_window_sum.sv
// Moving-average window sum
// Running I and Q sums over the last win_len samples, one output slot

`timescale 1ns/10ps

module mavg_window_sum
  import mavg_pkg::*;
#(
  parameter int MAX_LEN_LOG2 = 8
) (
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_clear,
  input  win_len_t i_win_len,
  input  logic     i_valid,
  input  part_t    i_i,
  input  part_t    i_q,
  input  logic     i_last,
  output logic     o_ready,
  output logic     o_valid,
  output sum_t     o_isum,
  output sum_t     o_qsum,
  output logic     o_last,
  input  logic     i_ready
);

  localparam int DEPTH = 2 ** MAX_LEN_LOG2;

  typedef logic [MAX_LEN_LOG2-1:0] ptr_t;

  // Sample history
  part_t    hist_i [DEPTH];
  part_t    hist_q [DEPTH];
  ptr_t     wr_ptr;
  win_len_t fill_cnt;
  sum_t     acc_i;
  sum_t     acc_q;

  // Window state after a possible clear in this cycle
  ptr_t     base_ptr;
  win_len_t base_fill;
  sum_t     base_i;
  sum_t     base_q;
  ptr_t     rd_ptr;
  part_t    old_i;
  part_t    old_q;
  sum_t     next_i;
  sum_t     next_q;
  logic     take;

  assign o_ready = ~o_valid | i_ready;
  assign take    = i_valid & o_ready;

  always_comb begin
    base_ptr  = i_clear ? '0 : wr_ptr;
    base_fill = i_clear ? '0 : fill_cnt;
    base_i    = i_clear ? '0 : acc_i;
    base_q    = i_clear ? '0 : acc_q;
    // Sample leaving the window
    rd_ptr    = base_ptr - ptr_t'(i_win_len);
    if (base_fill >= i_win_len) begin
      old_i = hist_i[rd_ptr];
      old_q = hist_q[rd_ptr];
    end else begin
      old_i = '0;
      old_q = '0;
    end
    next_i = base_i + sum_t'(i_i) - sum_t'(old_i);
    next_q = base_q + sum_t'(i_q) - sum_t'(old_q);
  end

  //--------------------------------------------------------------------
  // Window control
  //--------------------------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr   <= '0;
      fill_cnt <= '0;
      acc_i    <= '0;
      acc_q    <= '0;
      o_valid  <= 1'b0;
    end else begin
      if (i_clear) begin
        wr_ptr   <= '0;
        fill_cnt <= '0;
        acc_i    <= '0;
        acc_q    <= '0;
      end
      if (take) begin
        wr_ptr <= base_ptr + 1'b1;
        // Saturates, longest legal window is 255
        if (base_fill != 8'hFF) begin
          fill_cnt <= base_fill + 1'b1;
        end else begin
          fill_cnt <= base_fill;
        end
        acc_i <= next_i;
        acc_q <= next_q;
      end
      if (take) begin
        o_valid <= 1'b1;
      end else if (i_ready) begin
        o_valid <= 1'b0;
      end
    end
  end

  // History and output slot
  always_ff @(posedge i_clk) begin
    if (take) begin
      hist_i[base_ptr] <= i_i;
      hist_q[base_ptr] <= i_q;
      o_isum           <= next_i;
      o_qsum           <= next_q;
      o_last           <= i_last;
    end
  end

endmodule

// File: verilog/mavg_divider.sv
// Bit-serial signed divider for one lane
// Restoring division on magnitudes, quotient truncated toward zero

`timescale 1ns/10ps

module mavg_divider
  import mavg_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_valid,
  input  sum_t     i_dividend,
  input  divisor_t i_divisor,
  input  logic     i_last,
  output logic     o_ready,
  output logic     o_valid,
  output sum_t     o_quotient,
  output logic     o_last,
  input  logic     i_ready
);

  typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_FIX, ST_DONE} state_t;

  state_t      state;
  logic [4:0]  bit_cnt;
  logic [23:0] quo;
  logic [23:0] rem;
  logic [23:0] dvs;
  logic        neg;
  logic [23:0] dividend_mag;
  logic [23:0] divisor_mag;
  logic [24:0] rem_sh;
  logic [25:0] diff;

  assign o_ready = (state == ST_IDLE);
  assign o_valid = (state == ST_DONE);

  // Magnitudes, -2^23 maps to 2^23 as unsigned
  assign dividend_mag = i_dividend[23] ? 24'(-i_dividend) : 24'(i_dividend);
  assign divisor_mag  = i_divisor[23] ? -i_divisor : i_divisor;

  // Trial subtract of the shifted remainder
  assign rem_sh = {rem, quo[23]};
  assign diff   = {1'b0, rem_sh} - {2'b00, dvs};

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_valid) begin
            state   <= ST_SHIFT;
            bit_cnt <= '0;
          end
        end
        ST_SHIFT: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 5'd23) begin
            state <= ST_FIX;
          end
        end
        ST_FIX:  state <= ST_DONE;
        ST_DONE: begin
          if (i_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------

  always_ff @(posedge i_clk) begin
    case (state)
      ST_IDLE: begin
        // Divisor captured here, later writes do not disturb this division
        if (i_valid) begin
          quo    <= dividend_mag;
          rem    <= '0;
          dvs    <= divisor_mag;
          neg    <= i_dividend[23] ^ i_divisor[23];
          o_last <= i_last;
        end
      end
      ST_SHIFT: begin
        if (diff[25]) begin
          rem <= rem_sh[23:0];
          quo <= {quo[22:0], 1'b0};
        end else begin
          rem <= diff[23:0];
          quo <= {quo[22:0], 1'b1};
        end
      end
      ST_FIX:  o_quotient <= neg ? sum_t'(-quo) : sum_t'(quo);
      default: ;
    endcase
  end

endmodule

// File: verilog/mavg_iq_join.sv
// I/Q quotient join
// Packs the low 16 bits of both lane quotients into one output word

`timescale 1ns/10ps

module mavg_iq_join
  import mavg_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_i_valid,
  input  sum_t       i_i_quot,
  input  logic       i_i_last,
  input  logic       i_q_valid,
  input  sum_t       i_q_quot,
  output logic       o_lane_ready,
  output logic       o_valid,
  output iq_sample_t o_data,
  output logic       o_last,
  input  logic       i_ready
);

  part_t i_avg;
  part_t q_avg;
  logic  take;

  // Integer part only
  assign i_avg = i_i_quot[15:0];
  assign q_avg = i_q_quot[15:0];

  // Both lanes present and the slot free or draining
  assign take         = i_i_valid & i_q_valid & (~o_valid | i_ready);
  assign o_lane_ready = take;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
    end else if (take) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      o_data <= {i_avg, q_avg};
      o_last <= i_i_last;
    end
  end

endmodule

// File: verilog/mavg_top.sv
// Moving-average top level
// Settings decode, window sum, two lane dividers and the I/Q join

`timescale 1ns/10ps

module mavg_top
  import mavg_pkg::*;
#(
  parameter int MAX_LEN_LOG2 = 8
) (
  input  logic       i_clk,
  input  logic       i_reset,
  input  iq_sample_t i_data,
  input  logic       i_last,
  input  logic       i_valid,
  output logic       o_ready,
  output iq_sample_t o_data,
  output logic       o_last,
  output logic       o_valid,
  input  logic       i_ready,
  input  logic       i_set_stb,
  input  set_addr_t  i_set_addr,
  input  set_data_t  i_set_data,
  input  set_addr_t  i_rb_addr,
  output rb_data_t   o_rb_data
);

  // Settings
  win_len_t win_len;
  divisor_t divisor;
  logic     clear;

  // Input parts
  part_t    ipart;
  part_t    qpart;

  // Window sums
  sum_t     isum;
  sum_t     qsum;
  logic     sum_last;
  logic     sum_valid;
  logic     sum_ready;

  // Lane quotients
  sum_t     iavg;
  sum_t     qavg;
  logic     iavg_last;
  logic     iavg_valid;
  logic     qavg_valid;
  logic     idiv_ready;
  logic     qdiv_ready;
  logic     avg_ready;

  assign ipart = i_data[31:16];
  assign qpart = i_data[15:0];

  // Both dividers must take the sum pair
  assign sum_ready = idiv_ready & qdiv_ready;

  //--------------------------------------------------------------------
  // Stages
  //--------------------------------------------------------------------

  mavg_settings settings_inst (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_win_len  (win_len),
    .o_divisor  (divisor),
    .o_clear    (clear),
    .o_rb_data  (o_rb_data)
  );

  mavg_window_sum #(
    .MAX_LEN_LOG2 (MAX_LEN_LOG2)
  ) window_sum_inst (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_clear   (clear),
    .i_win_len (win_len),
    .i_valid   (i_valid),
    .i_i       (ipart),
    .i_q       (qpart),
    .i_last    (i_last),
    .o_ready   (o_ready),
    .o_valid   (sum_valid),
    .o_isum    (isum),
    .o_qsum    (qsum),
    .o_last    (sum_last),
    .i_ready   (sum_ready)
  );

  mavg_divider divide_i_inst (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_valid    (sum_valid),
    .i_dividend (isum),
    .i_divisor  (divisor),
    .i_last     (sum_last),
    .o_ready    (idiv_ready),
    .o_valid    (iavg_valid),
    .o_quotient (iavg),
    .o_last     (iavg_last),
    .i_ready    (avg_ready)
  );

  // Last flag comes from the I lane only
  mavg_divider divide_q_inst (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_valid    (sum_valid),
    .i_dividend (qsum),
    .i_divisor  (divisor),
    .i_last     (sum_last),
    .o_ready    (qdiv_ready),
    .o_valid    (qavg_valid),
    .o_quotient (qavg),
    .o_last     (),
    .i_ready    (avg_ready)
  );

  mavg_iq_join join_inst (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_i_valid    (iavg_valid),
    .i_i_quot     (iavg),
    .i_i_last     (iavg_last),
    .i_q_valid    (qavg_valid),
    .i_q_quot     (qavg),
    .o_lane_ready (avg_ready),
    .o_valid      (o_valid),
    .o_data       (o_data),
    .o_last       (o_last),
    .i_ready      (i_ready)
  );

endmodule

// File: sim/mavg_sva.sv
// Moving-average output stream assertions
// Reset behavior, hold under back-pressure and a known valid

`timescale 1ns/10ps

module mavg_sva (
  input logic        i_clk,
  input logic        i_reset,
  input logic        i_out_valid,
  input logic [31:0] i_out_data,
  input logic        i_out_last,
  input logic        i_out_ready
);

  // Output slot is empty once reset has been seen
  reset_clears_valid : assert property (@(posedge i_clk) i_reset |=> !i_out_valid)
    else $error("o_valid high during reset");

  // Held word must not move until it is taken
  hold_under_backpressure : assert property (@(posedge i_clk) disable iff (i_reset)
    (i_out_valid && !i_out_ready) |=> ($stable(i_out_data) && $stable(i_out_last)))
    else $error("o_data or o_last changed while stalled");

  valid_known : assert property (@(posedge i_clk) disable iff (i_reset)
    !$isunknown(i_out_valid))
    else $error("o_valid unknown after reset");

endmodule

// File: sim/mavg_tb.sv
// Moving-average testbench
// Random I/Q streams checked against a reference model, with settings and back-pressure

`timescale 1ns/10ps

module mavg_tb;

  localparam int          CLK_PERIOD  = 40;
  localparam int          TOTAL_WORDS = 193;
  localparam int          TIMEOUT_CYC = TOTAL_WORDS * 40 + 1000;
  localparam logic [7:0]  LEN_ADDR    = 8'd192;
  localparam logic [7:0]  DIV_ADDR    = 8'd193;
  localparam logic [63:0] BAD_PATTERN = 64'h0BAD_C0DE_0BAD_C0DE;

  logic        i_clk = 1'b0;
  logic        i_reset;
  logic [31:0] i_data;
  logic        i_last;
  logic        i_valid;
  logic        o_ready;
  logic [31:0] o_data;
  logic        o_last;
  logic        o_valid;
  logic        i_ready;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic [7:0]  i_rb_addr;
  logic [63:0] o_rb_data;

  int          seed = 32'h80a7;
  int          ready_seed = 32'h80a7;
  logic        random_ready;

  // Reference model state
  int          hist_i[$];
  int          hist_q[$];
  int          model_len;
  int          model_div;
  logic [31:0] exp_data[$];
  logic        exp_last[$];
  logic [31:0] want_data;
  logic        want_last;

  mavg_top #(
    .MAX_LEN_LOG2 (8)
  ) dut0 (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_data     (i_data),
    .i_last     (i_last),
    .i_valid    (i_valid),
    .o_ready    (o_ready),
    .o_data     (o_data),
    .o_last     (o_last),
    .o_valid    (o_valid),
    .i_ready    (i_ready),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data)
  );

  bind mavg_top mavg_sva sva0 (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_out_valid (o_valid),
    .i_out_data  (o_data),
    .i_out_last  (o_last),
    .i_out_ready (i_ready)
  );

  initial begin
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // Watchdog sized from the word count
  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("Timeout: the DUT did not return all words within %0d cycles", TIMEOUT_CYC);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  // Output back-pressure, low about one cycle in four when enabled
  initial begin
    i_ready = 1'b1;
    forever begin
      @(negedge i_clk);
      if (random_ready) begin
        i_ready = (($random(ready_seed) & 3) != 0);
      end else begin
        i_ready = 1'b1;
      end
    end
  end

  //--------------------------------------------------------------------
  // Reference model and checks
  //--------------------------------------------------------------------

  // Window sum with missing samples as zero, division toward zero, low 16 bits
  function automatic logic [31:0] model_word(input logic [31:0] din);
    logic signed [15:0] pi;
    logic signed [15:0] pq;
    int isum;
    int qsum;
    int iquot;
    int qquot;
    pi = din[31:16];
    pq = din[15:0];
    hist_i.push_front(int'(pi));
    hist_q.push_front(int'(pq));
    if (hist_i.size() > 255) begin
      void'(hist_i.pop_back());
      void'(hist_q.pop_back());
    end
    isum = 0;
    qsum = 0;
    for (int k = 0; k < model_len && k < hist_i.size(); k++) begin
      isum += hist_i[k];
      qsum += hist_q[k];
    end
    iquot = isum / model_div;
    qquot = qsum / model_div;
    return {iquot[15:0], qquot[15:0]};
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Compare every accepted output word with the oldest expected one
  always @(posedge i_clk) begin
    if (!i_reset && o_valid && i_ready) begin
      if (exp_data.size() == 0) begin
        $display("Output word %h arrived with no input word left to match it", o_data);
        $display("Test failed");
        $fatal(1, "extra output word");
      end else begin
        want_data = exp_data.pop_front();
        want_last = exp_last.pop_front();
        check_value({32'h0, o_data}, {32'h0, want_data}, "output data");
        check_value({63'h0, o_last}, {63'h0, want_last}, "output last flag");
      end
    end
  end

  //--------------------------------------------------------------------
  // Bus tasks, all entered on a falling edge
  //--------------------------------------------------------------------

  task automatic send_word(input logic [31:0] data, input logic last);
    logic accepted;
    accepted = 1'b0;
    i_valid  = 1'b1;
    i_data   = data;
    i_last   = last;
    while (!accepted) begin
      @(posedge i_clk);
      accepted = o_ready;
      @(negedge i_clk);
    end
    exp_data.push_back(model_word(data));
    exp_last.push_back(last);
    i_valid = 1'b0;
  endtask

  task automatic send_random(input int count, input int last_every);
    for (int n = 0; n < count; n++) begin
      send_word($random(seed), ((n + 1) % last_every) == 0);
    end
  endtask

  // Negative parts, so both sums are negative
  task automatic send_negative(input int count);
    int ival;
    int qval;
    for (int n = 0; n < count; n++) begin
      ival = -($random(seed) & 32'h7fff);
      qval = -($random(seed) & 32'h0fff);
      send_word({ival[15:0], qval[15:0]}, (n % 10) == 9);
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    if (addr == LEN_ADDR) begin
      model_len = data[7:0];
      hist_i.delete();
      hist_q.delete();
    end else if (addr == DIV_ADDR) begin
      model_div = data[23:0];
    end
    @(negedge i_clk);
    i_set_stb = 1'b0;
    // Let the clear pulse pass
    @(negedge i_clk);
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic [63:0] expected);
    i_rb_addr = addr;
    @(posedge i_clk);
    check_value(o_rb_data, expected, "readback data");
    @(negedge i_clk);
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) begin
      @(negedge i_clk);
    end
    repeat (2) @(negedge i_clk);
  endtask

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------

  initial begin
    i_reset      = 1'b1;
    i_data       = '0;
    i_last       = 1'b0;
    i_valid      = 1'b0;
    i_set_stb    = 1'b0;
    i_set_addr   = '0;
    i_set_data   = '0;
    i_rb_addr    = '0;
    random_ready = 1'b0;
    model_len    = 1;
    model_div    = 1;
    repeat (3) @(negedge i_clk);
    i_reset = 1'b0;

    // Empty pipeline after reset
    check_value({63'h0, o_ready}, 64'd1, "input ready after reset");
    check_value({63'h0, o_valid}, 64'd0, "output valid after reset");

    // Readback defaults and written values
    read_reg(8'd0, 64'd1);
    read_reg(8'd1, 64'd1);
    write_reg(LEN_ADDR, 32'd4);
    write_reg(DIV_ADDR, 32'd4);
    read_reg(8'd0, 64'd4);
    read_reg(8'd1, 64'd4);
    read_reg(8'd7, BAD_PATTERN);

    // Length 4 and divisor 4, starting from a partial window
    send_random(40, 10);
    wait_drain();

    // Length change mid-stream clears the history
    send_random(12, 6);
    write_reg(LEN_ADDR, 32'd6);
    send_random(18, 6);
    wait_drain();

    // Divisor unlike the length, negative sums
    write_reg(DIV_ADDR, 32'd7);
    write_reg(LEN_ADDR, 32'd5);
    read_reg(8'd1, 64'd7);
    send_negative(30);
    wait_drain();

    // Random output stalls
    random_ready = 1'b1;
    send_random(60, 7);
    wait_drain();
    random_ready = 1'b0;

    // Packets of 3 to 8 words
    for (int p = 0; p < 6; p++) begin
      for (int k = 0; k < p + 3; k++) begin
        send_word($random(seed), k == p + 2);
      end
    end
    wait_drain();

    // Longer than one pass through the dividers, so a repeated word shows up
    repeat (40) @(negedge i_clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: list.f
verilog/mavg_pkg.sv
verilog/mavg_settings.sv
verilog/mavg_window_sum.sv
verilog/mavg_divider.sv
verilog/mavg_iq_join.sv
verilog/mavg_top.sv
sim/mavg_sva.sv
sim/mavg_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the moving-average testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module mavg_tb -Mdir "$BUILD_DIR" -o mavg_sim -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/mavg_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
  echo "Simulation ended without a pass message"
  exit 1
fi
exit 0
